// File: hdl/lc3b_pkg.sv
package lc3b_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Basic data types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [15:0]  lc3b_word;       // One machine word.
    typedef logic [2:0]   lc3b_cc;         // Flags as {N, Z, P}.
    typedef logic [127:0] lc3b_line;       // Eight words per memory line.
    typedef logic [11:0]  lc3b_line_addr;  // Word address bits 15 to 4.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory geometry and timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Only this many lines are physically stored, so higher line
    // addresses alias onto them.
    localparam int LINE_COUNT = 64;
    localparam int LINE_IDX_W = $clog2(LINE_COUNT);

    localparam int BYTES_PER_LINE = 16;

    // Cycles from the first STB cycle seen by the slave to its ACK.
    localparam int ACK_DELAY = 2;
    localparam int ACK_CNT_W = $clog2(ACK_DELAY + 1);

    // Condition codes come out of reset showing zero.
    localparam lc3b_cc CC_ZERO = 3'b010;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        CC_FROM_ALU,
        CC_FROM_MDR,
        CC_FROM_SR2
    } cc_src_e;

    typedef enum logic [1:0] {
        ADDR_TRAPVECT,
        ADDR_ALU,
        ADDR_MDR    // Second access of an indirect load or store.
    } addr_src_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_READ,
        MEM_WRITE
    } mem_op_e;

    typedef struct packed {
        mem_op_e    mem_op;
        addr_src_e  addr_sel;
        cc_src_e    cc_sel;
        logic       cc_load;
        logic       mdr_load;   // Capture the read word for a later indirect access.
        logic [1:0] byte_sel;   // Bit 0 enables the low byte, bit 1 the high byte.
    } lc3b_control_word;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone classic bus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic          cyc;
        logic          stb;
        logic          we;
        lc3b_line_addr adr;
        logic [15:0]   sel;  // One select per byte of the line.
        lc3b_line      dat;
    } wb_m2s_t;

    typedef struct packed {
        logic     ack;
        lc3b_line dat;
    } wb_s2m_t;

endpackage

// File: hdl/cc_gen.sv
`timescale 1ns/1ps

module cc_gen (
    input  logic              clk,
    input  logic              rst,
    input  lc3b_pkg::cc_src_e sel,
    input  logic              load,
    input  lc3b_pkg::lc3b_word alu_in,
    input  lc3b_pkg::lc3b_word mdr_in,
    input  lc3b_pkg::lc3b_word sr2_in,
    output lc3b_pkg::lc3b_cc  cc_out
);
    import lc3b_pkg::*;

    lc3b_word src;
    lc3b_cc   cc_next;

    always_comb begin
        case (sel)
            CC_FROM_MDR: src = mdr_in;
            CC_FROM_SR2: src = sr2_in;
            default:     src = alu_in;
        endcase
    end

    // Negative wins on bit 15; zero and positive split the rest.
    always_comb begin
        if (src[15]) begin
            cc_next = 3'b100;
        end else if (src == '0) begin
            cc_next = 3'b010;
        end else begin
            cc_next = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cc_out <= CC_ZERO;
        end else if (load) begin
            cc_out <= cc_next;
        end
    end

    // The flags form a one-hot code through every load.
    a_cc_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot(cc_out));

endmodule

// File: hdl/stage_mem.sv
`timescale 1ns/1ps

module stage_mem (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  lc3b_pkg::lc3b_control_word control_in,
    input  lc3b_pkg::lc3b_word        alu_in,
    input  lc3b_pkg::lc3b_word        ir_in,
    input  lc3b_pkg::lc3b_word        sr2_in,
    output logic                      busy,
    output logic                      done,
    output lc3b_pkg::lc3b_cc          cc_out,
    output lc3b_pkg::lc3b_word        mdr_out,
    output lc3b_pkg::wb_m2s_t         wb_out,
    input  lc3b_pkg::wb_s2m_t         wb_in
);
    import lc3b_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,     // Waiting for ACK from the memory.
        ST_FINISH   // Request without a bus access.
    } stage_state_e;

    stage_state_e     state;
    lc3b_control_word ctrl_q;
    logic             accept;

    lc3b_word  trapvect8;
    lc3b_word  data_addr;
    logic [2:0] lane;
    logic [2:0] lane_q;
    logic [15:0] sel_next;
    lc3b_line   dat_next;

    logic          cyc_q;
    logic          stb_q;
    logic          we_q;
    lc3b_line_addr adr_q;
    logic [15:0]   sel_q;
    lc3b_line      dat_q;

    lc3b_word internal_mdr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address selection and lane placement
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign trapvect8 = {7'b0, ir_in[7:0], 1'b0};  // Word-aligned trap table entry.

    always_comb begin
        case (control_in.addr_sel)
            ADDR_TRAPVECT: data_addr = trapvect8;
            ADDR_MDR:      data_addr = internal_mdr;
            default:       data_addr = alu_in;
        endcase
    end

    assign lane = data_addr[3:1];

    always_comb begin
        sel_next = '0;
        sel_next[lane*2 +: 2] = control_in.byte_sel;
        dat_next = '0;
        dat_next[lane*16 +: 16] = sr2_in;  // Other lanes are masked by sel.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request handling and bus cycle control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign accept = (state == ST_IDLE) && req;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= (control_in.mem_op == MEM_NONE) ? ST_FINISH : ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (wb_in.ack) begin
                        state <= ST_IDLE;
                    end
                end
                ST_FINISH: state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
            we_q  <= 1'b0;
        end else if (accept && control_in.mem_op != MEM_NONE) begin
            cyc_q <= 1'b1;
            stb_q <= 1'b1;
            we_q  <= (control_in.mem_op == MEM_WRITE);
        end else if (state == ST_BUS && wb_in.ack) begin
            cyc_q <= 1'b0;  // Released in the cycle after ACK.
            stb_q <= 1'b0;
            we_q  <= 1'b0;
        end
    end

    // The request is captured once and held for the whole access.
    always_ff @(posedge clk) begin
        if (accept) begin
            ctrl_q <= control_in;
            lane_q <= lane;
            adr_q  <= data_addr[15:4];
            sel_q  <= sel_next;
            dat_q  <= dat_next;
        end
    end

    assign wb_out = '{cyc: cyc_q, stb: stb_q, we: we_q, adr: adr_q, sel: sel_q, dat: dat_q};

    assign busy = (state != ST_IDLE);
    assign done = (state == ST_BUS && wb_in.ack) || (state == ST_FINISH);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read data, internal data register and condition codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign mdr_out = wb_in.dat[lane_q*16 +: 16];

    always_ff @(posedge clk) begin
        if (rst) begin
            internal_mdr <= '0;
        end else if (done && ctrl_q.mdr_load && ctrl_q.mem_op == MEM_READ) begin
            internal_mdr <= mdr_out;
        end
    end

    cc_gen u_cc_gen (
        .clk    (clk),
        .rst    (rst),
        .sel    (ctrl_q.cc_sel),
        .load   (done && ctrl_q.cc_load),
        .alu_in (alu_in),
        .mdr_in (mdr_out),
        .sr2_in (sr2_in),
        .cc_out (cc_out)
    );

    a_stb_has_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_out.stb |-> wb_out.cyc);

    // Master outputs may not move until the slave has acknowledged.
    a_bus_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_out.stb && !wb_in.ack) |=> $stable(wb_out));

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done);

endmodule

// File: hdl/line_memory.sv
`timescale 1ns/1ps

module line_memory (
    input  logic              clk,
    input  logic              rst,
    input  lc3b_pkg::wb_m2s_t wb_in,
    output lc3b_pkg::wb_s2m_t wb_out
);
    import lc3b_pkg::*;

    lc3b_line mem [LINE_COUNT];

    logic [LINE_IDX_W-1:0] idx;
    logic [ACK_CNT_W-1:0]  wait_cnt;
    logic                  ack_q;
    lc3b_line              rd_q;
    logic                  active;
    logic                  fire;

    // Upper line address bits are ignored, so the array repeats
    // across the address space.
    assign idx = wb_in.adr[LINE_IDX_W-1:0];

    // A cycle is pending while the master strobes and no ACK is out.
    assign active = wb_in.cyc && wb_in.stb && !ack_q;
    assign fire   = active && (wait_cnt == ACK_CNT_W'(ACK_DELAY - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Acknowledge timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
            ack_q    <= 1'b0;
        end else begin
            ack_q <= fire;  // Single-cycle ACK.
            if (fire || !active) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage access
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The array is touched on the edge that raises ACK, so read data
    // sits in rd_q for the whole ACK cycle.
    always_ff @(posedge clk) begin
        if (fire) begin
            if (wb_in.we) begin
                for (int b = 0; b < BYTES_PER_LINE; b++) begin
                    if (wb_in.sel[b]) begin
                        mem[idx][b*8 +: 8] <= wb_in.dat[b*8 +: 8];
                    end
                end
            end else begin
                rd_q <= mem[idx];
            end
        end
    end

    assign wb_out = '{ack: ack_q, dat: rd_q};

    // The master holds STB through the ACK cycle, so an ACK seen
    // without it means the two sides lost step.
    a_ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
        wb_out.ack |-> wb_in.stb);

endmodule

// File: hdl/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  lc3b_pkg::lc3b_control_word control_in,
    input  lc3b_pkg::lc3b_word        alu_in,
    input  lc3b_pkg::lc3b_word        ir_in,
    input  lc3b_pkg::lc3b_word        sr2_in,
    output logic                      busy,
    output logic                      done,
    output lc3b_pkg::lc3b_cc          cc_out,
    output lc3b_pkg::lc3b_word        mdr_out
);
    import lc3b_pkg::*;

    wb_m2s_t wb_m2s;  // Stage to memory.
    wb_s2m_t wb_s2m;  // Memory to stage.

    stage_mem u_stage_mem (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .control_in (control_in),
        .alu_in     (alu_in),
        .ir_in      (ir_in),
        .sr2_in     (sr2_in),
        .busy       (busy),
        .done       (done),
        .cc_out     (cc_out),
        .mdr_out    (mdr_out),
        .wb_out     (wb_m2s),
        .wb_in      (wb_s2m)
    );

    line_memory u_line_memory (
        .clk    (clk),
        .rst    (rst),
        .wb_in  (wb_m2s),
        .wb_out (wb_s2m)
    );

endmodule

// File: sim/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;
    import lc3b_pkg::*;

    localparam int N_TABLE         = 21;
    localparam int N_RANDOM        = 40;
    localparam int CYCLES_PER_TEST = 10;
    localparam int DONE_LIMIT      = 20;  // Cycles to wait for done before giving up.
    localparam int WATCHDOG_NS     = (N_TABLE + N_RANDOM + 2) * CYCLES_PER_TEST * 10 + 1000;

    localparam lc3b_cc CC_N = 3'b100;
    localparam lc3b_cc CC_Z = 3'b010;
    localparam lc3b_cc CC_P = 3'b001;

    typedef struct {
        lc3b_control_word ctrl;
        lc3b_word         alu;
        lc3b_word         ir;
        lc3b_word         sr2;
        lc3b_word         exp_mdr;
        lc3b_cc           exp_cc;
    } vector_t;

    logic             clk;
    logic             rst;
    logic             req;
    lc3b_control_word control_in;
    lc3b_word         alu_in;
    lc3b_word         ir_in;
    lc3b_word         sr2_in;
    logic             busy;
    logic             done;
    lc3b_cc           cc_out;
    lc3b_word         mdr_out;

    vector_t  vecs [N_TABLE];
    int       n_vec;
    int       errors;
    int       checks;
    int       seed;
    lc3b_word ref_mem [int];  // Sparse word model keyed by stored line and lane.
    int       ref_keys [$];

    mem_subsystem_top uut (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .control_in (control_in),
        .alu_in     (alu_in),
        .ir_in      (ir_in),
        .sr2_in     (sr2_in),
        .busy       (busy),
        .done       (done),
        .cc_out     (cc_out),
        .mdr_out    (mdr_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests completed.", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic lc3b_cc expect_cc(lc3b_word w);
        if (w[15]) return CC_N;
        if (w == 16'h0000) return CC_Z;
        return CC_P;
    endfunction

    // Lines alias modulo LINE_COUNT; the lane is address bits 3 to 1.
    function automatic int word_key(lc3b_word addr);
        return (int'(addr[15:4]) % LINE_COUNT) * 8 + int'(addr[3:1]);
    endfunction

    function automatic void model_write(lc3b_word addr, lc3b_word data, logic [1:0] bs);
        int       key;
        lc3b_word old;
        key = word_key(addr);
        if (!ref_mem.exists(key)) begin
            ref_mem[key] = data;  // First writes to a word are always full words.
            ref_keys.push_back(key);
            return;
        end
        old = ref_mem[key];
        if (bs[0]) old[7:0] = data[7:0];
        if (bs[1]) old[15:8] = data[15:8];
        ref_mem[key] = old;
    endfunction

    function automatic lc3b_control_word make_ctrl(mem_op_e op, addr_src_e asel,
            cc_src_e csel, logic ccl, logic mdrl, logic [1:0] bs);
        lc3b_control_word c;
        c.mem_op   = op;
        c.addr_sel = asel;
        c.cc_sel   = csel;
        c.cc_load  = ccl;
        c.mdr_load = mdrl;
        c.byte_sel = bs;
        return c;
    endfunction

    function automatic void add_row(mem_op_e op, addr_src_e asel, cc_src_e csel, logic ccl,
            logic mdrl, logic [1:0] bs, lc3b_word alu, lc3b_word ir, lc3b_word sr2,
            lc3b_word exp_mdr, lc3b_cc exp_cc);
        vecs[n_vec] = '{make_ctrl(op, asel, csel, ccl, mdrl, bs), alu, ir, sr2,
                        exp_mdr, exp_cc};
        n_vec++;
    endfunction

    task automatic build_table();
        // Word stores and reads in neighbouring lanes.
        add_row(MEM_NONE, ADDR_ALU, CC_FROM_ALU, 1, 0, 3, 'h8000, 'h0000, 'h0000, 'h0000, CC_N);
        add_row(MEM_WRITE, ADDR_ALU, CC_FROM_SR2, 1, 0, 3, 'h1234, 'h0000, 'hBEEF, 'h0, CC_N);
        add_row(MEM_WRITE, ADDR_ALU, CC_FROM_SR2, 1, 0, 3, 'h1236, 'h0000, 'h0F0F, 'h0, CC_P);
        add_row(MEM_READ, ADDR_ALU, CC_FROM_MDR, 1, 0, 3, 'h1234, 'h0000, 'h0000, 'hBEEF, CC_N);
        add_row(MEM_READ, ADDR_ALU, CC_FROM_MDR, 1, 0, 3, 'h1236, 'h0000, 'h0000, 'h0F0F, CC_P);
        // Byte-select stores merge into the word; cc_load clear holds the flags.
        add_row(MEM_WRITE, ADDR_ALU, CC_FROM_SR2, 0, 0, 1, 'h1234, 'h0000, 'h8055, 'h0, CC_P);
        add_row(MEM_READ, ADDR_ALU, CC_FROM_MDR, 0, 0, 3, 'h1234, 'h0000, 'h0000, 'hBE55, CC_P);
        add_row(MEM_WRITE, ADDR_ALU, CC_FROM_ALU, 1, 0, 2, 'h1234, 'h0000, 'h77AA, 'h0, CC_P);
        add_row(MEM_READ, ADDR_ALU, CC_FROM_MDR, 1, 0, 3, 'h1234, 'h0000, 'h0000, 'h7755, CC_P);
        add_row(MEM_READ, ADDR_ALU, CC_FROM_MDR, 1, 0, 3, 'hF634, 'h0000, 'h0000, 'h7755, CC_P);
        // Trap table entry at 0x004A points at 0x3000 for the indirect read.
        add_row(MEM_WRITE, ADDR_ALU, CC_FROM_SR2, 1, 0, 3, 'h3000, 'h0000, 'h8001, 'h0, CC_N);
        add_row(MEM_WRITE, ADDR_ALU, CC_FROM_SR2, 1, 0, 3, 'h004A, 'h0000, 'h3000, 'h0, CC_P);
        add_row(MEM_READ, ADDR_TRAPVECT, CC_FROM_MDR, 1, 1, 3, 'h0, 'hF025, 'h0, 'h3000, CC_P);
        add_row(MEM_READ, ADDR_MDR, CC_FROM_MDR, 1, 0, 3, 'h0000, 'h0000, 'h0000, 'h8001, CC_N);
        add_row(MEM_WRITE, ADDR_ALU, CC_FROM_SR2, 1, 0, 3, 'h0040, 'h0000, 'h0000, 'h0, CC_Z);
        add_row(MEM_READ, ADDR_ALU, CC_FROM_MDR, 1, 0, 3, 'h0040, 'h0000, 'h0000, 'h0000, CC_Z);
        add_row(MEM_READ, ADDR_TRAPVECT, CC_FROM_MDR, 1, 0, 3, 'h0, 'h0025, 'h0, 'h3000, CC_P);
        // Flag-only requests.
        add_row(MEM_NONE, ADDR_ALU, CC_FROM_ALU, 1, 0, 3, 'h7FFF, 'h0000, 'h0000, 'h0000, CC_P);
        add_row(MEM_NONE, ADDR_ALU, CC_FROM_ALU, 1, 0, 3, 'h0000, 'h0000, 'h8000, 'h0000, CC_Z);
        add_row(MEM_NONE, ADDR_ALU, CC_FROM_ALU, 0, 0, 3, 'h8000, 'h0000, 'h0000, 'h0000, CC_Z);
        add_row(MEM_NONE, ADDR_ALU, CC_FROM_SR2, 1, 0, 3, 'h0000, 'h0000, 'hFFFF, 'h0000, CC_N);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and access sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic flag_error(input string msg);
        errors++;
        $display("%s (at %0t)", msg, $time);
    endtask

    task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h (at %0t)", name, got, exp, $time);
        end
    endtask

    task automatic check_cc(input string name, input lc3b_cc got, input lc3b_cc exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h (at %0t)", name, got, exp, $time);
        end
    endtask

    // Read data is taken in the done cycle, the flags one cycle later.
    task automatic run_access(input lc3b_control_word c, input lc3b_word alu,
            input lc3b_word ir, input lc3b_word sr2,
            output lc3b_word mdr_seen, output lc3b_cc cc_seen);
        int lat;
        int exp_lat;
        exp_lat = (c.mem_op == MEM_NONE) ? 1 : 3;
        @(posedge clk);
        control_in <= c;
        alu_in     <= alu;
        ir_in      <= ir;
        sr2_in     <= sr2;
        req        <= 1'b1;
        @(posedge clk);
        req <= 1'b0;
        lat = 0;
        mdr_seen = 'x;
        do begin
            @(negedge clk);
            lat++;
            if (lat == 1 && busy !== 1'b1) flag_error("busy was not raised for the request");
        end while (done !== 1'b1 && lat < DONE_LIMIT);
        cc_seen = cc_out;
        if (done !== 1'b1) begin
            flag_error($sformatf("No done pulse arrived within %0d cycles", DONE_LIMIT));
            return;
        end
        mdr_seen = mdr_out;
        if (lat != exp_lat) begin
            flag_error($sformatf("Access took %0d cycles to done, expected %0d", lat, exp_lat));
        end
        @(negedge clk);
        if (done !== 1'b0) flag_error("done stayed high for more than one cycle");
        cc_seen = cc_out;
    endtask

    // A second req pulse lands while the read is still on the bus.
    task automatic stray_request_test();
        int lat;
        int extra;
        @(posedge clk);
        control_in <= make_ctrl(MEM_READ, ADDR_ALU, CC_FROM_MDR, 1'b0, 1'b0, 2'b11);
        alu_in     <= 16'h1234;
        req        <= 1'b1;
        @(posedge clk);
        req <= 1'b0;
        @(posedge clk);
        req <= 1'b1;
        @(posedge clk);
        req <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (done !== 1'b1 && lat < DONE_LIMIT);
        if (done !== 1'b1) flag_error("The read with a stray request never finished");
        extra = 0;
        repeat (8) begin
            @(negedge clk);
            if (done === 1'b1) extra++;
        end
        if (extra != 0) flag_error($sformatf("A request during busy gave %0d extra done", extra));
        if (busy !== 1'b0) flag_error("busy stayed high after the access finished");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        lc3b_word         mdr_seen;
        lc3b_cc           cc_seen;
        lc3b_word         addr;
        lc3b_word         data;
        lc3b_control_word c;
        logic [1:0]       bs;
        int               key;
        int               rnd;
        seed       = 17;
        errors     = 0;
        checks     = 0;
        n_vec      = 0;
        rst        = 1'b1;
        req        = 1'b0;
        control_in = '0;
        alu_in     = '0;
        ir_in      = '0;
        sr2_in     = '0;
        build_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_cc("cc_out after reset", cc_out, CC_Z);
        if (busy !== 1'b0 || done !== 1'b0) flag_error("busy or done is high after reset");

        for (int i = 0; i < N_TABLE; i++) begin
            run_access(vecs[i].ctrl, vecs[i].alu, vecs[i].ir, vecs[i].sr2, mdr_seen, cc_seen);
            if (vecs[i].ctrl.mem_op == MEM_READ) begin
                check_word($sformatf("mdr_out (row %0d)", i), mdr_seen, vecs[i].exp_mdr);
            end
            check_cc($sformatf("cc_out (row %0d)", i), cc_seen, vecs[i].exp_cc);
            if (vecs[i].ctrl.mem_op == MEM_WRITE) begin
                model_write(vecs[i].alu, vecs[i].sr2, vecs[i].ctrl.byte_sel);
            end
        end

        stray_request_test();

        for (int n = 0; n < N_RANDOM; n++) begin
            rnd = $random(seed);
            if (ref_keys.size() == 0 || rnd[0]) begin
                rnd  = $random(seed);
                addr = rnd[15:0];
                data = rnd[31:16];
                key  = word_key(addr);
                rnd  = $random(seed);
                bs   = ref_mem.exists(key) ? rnd[1:0] : 2'b11;
                c    = make_ctrl(MEM_WRITE, ADDR_ALU, CC_FROM_SR2, 1'b1, 1'b0, bs);
                run_access(c, addr, 16'h0000, data, mdr_seen, cc_seen);
                model_write(addr, data, bs);
                check_cc("cc_out (random write)", cc_seen, expect_cc(data));
            end else begin
                rnd  = $random(seed);
                key  = ref_keys[$unsigned(rnd) % ref_keys.size()];
                rnd  = $random(seed);
                addr = {rnd[15:10], key[8:0], rnd[0]};  // Random upper bits alias the line.
                c    = make_ctrl(MEM_READ, ADDR_ALU, CC_FROM_MDR, 1'b1, 1'b0, 2'b11);
                run_access(c, addr, 16'h0000, 16'h0000, mdr_seen, cc_seen);
                check_word("mdr_out (random read)", mdr_seen, ref_mem[key]);
                check_cc("cc_out (random read)", cc_seen, expect_cc(ref_mem[key]));
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: list.f
hdl/lc3b_pkg.sv
hdl/cc_gen.sv
hdl/stage_mem.sv
hdl/line_memory.sv
hdl/mem_subsystem_top.sv
sim/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: lc3b_mem_subsystem

sources:
  # Package first, then the RTL from the leaves up to the top level.
  - hdl/lc3b_pkg.sv
  - hdl/cc_gen.sv
  - hdl/stage_mem.sv
  - hdl/line_memory.sv
  - hdl/mem_subsystem_top.sv

  - target: simulation
    files:
      - sim/tb_mem_subsystem.sv
